// ==== src/id_pkg.sv ====
// shared widths, encodings and types of the decode stage, imported by every design unit
`default_nettype none

package id_pkg;

  localparam int XLEN        = 64;
  localparam int INST_WD     = 32;
  localparam int GPR_ADDR_WD = 5;

  localparam logic [INST_WD-1:0] NOP_INST = 32'h0000_0013; // addi x0, x0, 0

  // major opcodes of the supported subset
  typedef enum logic [6:0] {
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011,
    OPC_LOAD   = 7'b0000011,
    OPC_STORE  = 7'b0100011,
    OPC_OP_IMM = 7'b0010011,
    OPC_OP     = 7'b0110011
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
    ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
  } alu_op_e;

  typedef enum logic [3:0] {
    BR_NONE, BR_BEQ, BR_BNE, BR_BLT, BR_BGE, BR_BLTU, BR_BGEU, BR_JAL, BR_JALR
  } br_op_e;

  // same values as funct3 of loads and stores
  typedef enum logic [2:0] {
    MEM_B  = 3'd0,
    MEM_H  = 3'd1,
    MEM_W  = 3'd2,
    MEM_D  = 3'd3,
    MEM_BU = 3'd4,
    MEM_HU = 3'd5,
    MEM_WU = 3'd6
  } mem_op_e;

  typedef enum logic {SRC1_RS1, SRC1_PC} src1_sel_e;

  typedef enum logic [1:0] {SRC2_RS2, SRC2_IMM, SRC2_FOUR} src2_sel_e;

  // one bypass source from a later stage
  typedef struct packed {
    logic [GPR_ADDR_WD-1:0] rd;
    logic [XLEN-1:0]        data;
  } fwd_t;

endpackage

`default_nettype wire

// ==== src/decode_if.sv ====
// decoded instruction fields, driven by the decoder and read by the operand, branch and stage logic
`timescale 1ns/1ns
`default_nettype none

interface decode_if import id_pkg::*; ();

  logic [GPR_ADDR_WD-1:0] rs1;
  logic [GPR_ADDR_WD-1:0] rs2;
  logic [GPR_ADDR_WD-1:0] rd;
  logic [XLEN-1:0]        imm;
  br_op_e                 br_op;
  alu_op_e                alu_op;
  src1_sel_e              src1_sel;
  src2_sel_e              src2_sel;
  logic                   gpr_wen;
  logic                   mem_ren;
  logic                   mem_wen;
  mem_op_e                mem_op;
  logic                   load_sel; // needs a stall when consumed next
  logic                   invalid;

  modport decoder (
    output rs1, rs2, rd, imm, br_op, alu_op, src1_sel, src2_sel,
           gpr_wen, mem_ren, mem_wen, mem_op, load_sel, invalid
  );

  modport operand (input rs1, rs2);

  modport branch (input br_op, imm);

  modport stage (
    input rd, imm, alu_op, src1_sel, src2_sel, gpr_wen, mem_ren, mem_wen,
          mem_op, load_sel, invalid
  );

endinterface

`default_nettype wire

// ==== src/id_decoder.sv ====
// combinational decoder of the RV64I subset, fills decode_if from the latched instruction
`timescale 1ns/1ns
`default_nettype none

module id_decoder import id_pkg::*; (
  input  logic [INST_WD-1:0] i_inst,
  decode_if.decoder          dif
);

  opcode_e                opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [GPR_ADDR_WD-1:0] rd_field;
  logic [XLEN-1:0]        imm_i, imm_s, imm_b, imm_u, imm_j;
  logic                   use_rs1;
  logic                   use_rs2;
  logic                   use_rd;
  logic                   bad_shift;

  function automatic alu_op_e alu_from_f3(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  return alt ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return alt ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  assign opcode   = opcode_e'(i_inst[6:0]);
  assign funct3   = i_inst[14:12];
  assign funct7   = i_inst[31:25];
  assign rd_field = i_inst[11:7];

  assign imm_i = {{(XLEN-12){i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{(XLEN-12){i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{(XLEN-13){i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25],
                  i_inst[11:8], 1'b0};
  assign imm_u = {{(XLEN-32){i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{(XLEN-21){i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20],
                  i_inst[30:21], 1'b0};

  // rv64 shamt is 6 bits, only bit 30 may differ
  assign bad_shift = (funct3 == 3'b001 && funct7[6:1] != 6'b000000) ||
                     (funct3 == 3'b101 && funct7[6:1] != 6'b000000 &&
                      funct7[6:1] != 6'b010000);

  always_comb begin
    dif.alu_op   = ALU_ADD;
    dif.src1_sel = SRC1_RS1;
    dif.src2_sel = SRC2_IMM;
    dif.br_op    = BR_NONE;
    dif.imm      = imm_i;
    dif.mem_ren  = 1'b0;
    dif.mem_wen  = 1'b0;
    dif.mem_op   = mem_op_e'(funct3);
    dif.load_sel = 1'b0;
    dif.invalid  = 1'b0;
    use_rs1      = 1'b0;
    use_rs2      = 1'b0;
    use_rd       = 1'b0;
    case (opcode)
      OPC_LUI: begin
        dif.alu_op = ALU_PASS_B;
        dif.imm    = imm_u;
        use_rd     = 1'b1;
      end
      OPC_AUIPC: begin
        dif.src1_sel = SRC1_PC;
        dif.imm      = imm_u;
        use_rd       = 1'b1;
      end
      OPC_JAL: begin
        dif.src1_sel = SRC1_PC;
        dif.src2_sel = SRC2_FOUR; // link value pc+4
        dif.br_op    = BR_JAL;
        dif.imm      = imm_j;
        use_rd       = 1'b1;
      end
      OPC_JALR: begin
        dif.src1_sel = SRC1_PC;
        dif.src2_sel = SRC2_FOUR;
        dif.br_op    = BR_JALR;
        dif.invalid  = (funct3 != 3'b000);
        use_rs1      = 1'b1;
        use_rd       = 1'b1;
      end
      OPC_BRANCH: begin
        dif.imm = imm_b;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
        case (funct3)
          3'b000:  dif.br_op = BR_BEQ;
          3'b001:  dif.br_op = BR_BNE;
          3'b100:  dif.br_op = BR_BLT;
          3'b101:  dif.br_op = BR_BGE;
          3'b110:  dif.br_op = BR_BLTU;
          3'b111:  dif.br_op = BR_BGEU;
          default: dif.invalid = 1'b1;
        endcase
      end
      OPC_LOAD: begin
        dif.mem_ren  = 1'b1;
        dif.load_sel = 1'b1;
        dif.invalid  = (funct3 == 3'b111);
        use_rs1      = 1'b1;
        use_rd       = 1'b1;
      end
      OPC_STORE: begin
        dif.mem_wen = 1'b1;
        dif.imm     = imm_s;
        dif.invalid = funct3[2]; // only sb..sd
        use_rs1     = 1'b1;
        use_rs2     = 1'b1;
      end
      OPC_OP_IMM: begin
        dif.alu_op  = alu_from_f3(funct3, funct3 == 3'b101 && funct7[5]);
        dif.invalid = bad_shift;
        use_rs1     = 1'b1;
        use_rd      = 1'b1;
      end
      OPC_OP: begin
        dif.alu_op   = alu_from_f3(funct3, funct7[5]);
        dif.src2_sel = SRC2_RS2;
        dif.invalid  = !(funct7 == 7'h00 ||
                         (funct7 == 7'h20 && (funct3 == 3'b000 || funct3 == 3'b101)));
        use_rs1      = 1'b1;
        use_rs2      = 1'b1;
        use_rd       = 1'b1;
      end
      default: dif.invalid = 1'b1;
    endcase
    if (dif.invalid) begin // squash every side effect
      dif.br_op    = BR_NONE;
      dif.mem_ren  = 1'b0;
      dif.mem_wen  = 1'b0;
      dif.load_sel = 1'b0;
      use_rd       = 1'b0;
    end
  end

  // unused source fields read as x0 so they never hit a bypass or stall
  assign dif.rs1     = use_rs1 ? i_inst[19:15] : '0;
  assign dif.rs2     = use_rs2 ? i_inst[24:20] : '0;
  assign dif.rd      = use_rd ? rd_field : '0;
  assign dif.gpr_wen = use_rd && (rd_field != '0);

endmodule

`default_nettype wire

// ==== src/id_gpr_file.sv ====
// general register file, two async read ports and the write-back port, x0 reads as zero
`timescale 1ns/1ns
`default_nettype none

module id_gpr_file import id_pkg::*; #(
  parameter int XLEN = id_pkg::XLEN
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  input  logic [GPR_ADDR_WD-1:0] i_raddr1,
  input  logic [GPR_ADDR_WD-1:0] i_raddr2,
  input  logic                   i_wen,
  input  logic [GPR_ADDR_WD-1:0] i_waddr,
  input  logic [XLEN-1:0]        i_wdata,
  output logic [XLEN-1:0]        o_rdata1,
  output logic [XLEN-1:0]        o_rdata2
);

  logic [XLEN-1:0] regs [1:31]; // x0 has no storage

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && i_waddr != '0) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  // no write-through, same cycle data comes from the bypass
  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

`default_nettype wire

// ==== src/id_operand_bypass.sv ====
// operand forwarding from ex, mem and wb with load-use hazard detection
`timescale 1ns/1ns
`default_nettype none

module id_operand_bypass import id_pkg::*; (
  decode_if.operand       op,
  input  logic [XLEN-1:0] i_rf_rdata1,
  input  logic [XLEN-1:0] i_rf_rdata2,
  input  fwd_t            i_es_fwd,
  input  fwd_t            i_ms_fwd,
  input  fwd_t            i_ws_fwd,
  input  logic            i_es_load_sel,
  output logic [XLEN-1:0] o_rs1_data,
  output logic [XLEN-1:0] o_rs2_data,
  output logic            o_load_stall
);

  // youngest producer wins; rs of x0 never matches, so neither does rd 0
  function automatic logic [XLEN-1:0] pick(input logic [GPR_ADDR_WD-1:0] rs,
                                           input logic [XLEN-1:0] rf_data,
                                           input fwd_t es, input fwd_t ms, input fwd_t ws);
    if (rs == '0) return rf_data;
    if (rs == es.rd) return es.data;
    if (rs == ms.rd) return ms.data;
    if (rs == ws.rd) return ws.data;
    return rf_data;
  endfunction

  assign o_rs1_data = pick(op.rs1, i_rf_rdata1, i_es_fwd, i_ms_fwd, i_ws_fwd);
  assign o_rs2_data = pick(op.rs2, i_rf_rdata2, i_es_fwd, i_ms_fwd, i_ws_fwd);

  // load data not ready until the load reaches mem
  assign o_load_stall = i_es_load_sel && (i_es_fwd.rd != '0) &&
                        ((i_es_fwd.rd == op.rs1) || (i_es_fwd.rd == op.rs2));

endmodule

`default_nettype wire

// ==== src/id_branch_unit.sv ====
// branch condition, target adder and fetch redirect, resolved only on issue
`timescale 1ns/1ns
`default_nettype none

module id_branch_unit import id_pkg::*; (
  decode_if.branch        br,
  input  logic            i_issue,
  input  logic [XLEN-1:0] i_rs1_data,
  input  logic [XLEN-1:0] i_rs2_data,
  input  logic [XLEN-1:0] i_ds_pc,
  input  logic [XLEN-1:0] i_fs_pc,
  output logic            o_br_sel,
  output logic            o_br_taken,
  output logic [XLEN-1:0] o_br_target
);

  logic eq;
  logic lt_s;
  logic lt_u;
  logic cond;

  assign eq   = (i_rs1_data == i_rs2_data);
  assign lt_s = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign lt_u = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (br.br_op)
      BR_BEQ:          cond = eq;
      BR_BNE:          cond = !eq;
      BR_BLT:          cond = lt_s;
      BR_BGE:          cond = !lt_s;
      BR_BLTU:         cond = lt_u;
      BR_BGEU:         cond = !lt_u;
      BR_JAL, BR_JALR: cond = 1'b1;
      default:         cond = 1'b0;
    endcase
  end

  assign o_br_target = (br.br_op == BR_JALR) ? ((i_rs1_data + br.imm) & ~XLEN'(1))
                                             : (i_ds_pc + br.imm);
  assign o_br_sel    = i_issue && cond;
  // fetch already on the right path, nothing to flush
  assign o_br_taken  = o_br_sel && (o_br_target != i_fs_pc);

endmodule

`default_nettype wire

// ==== src/id_pipe_reg.sv ====
// decode stage register: valid bit, instruction and pc, allowin and NOP flush on redirect
`timescale 1ns/1ns
`default_nettype none

module id_pipe_reg import id_pkg::*; (
  input  logic               i_clk,
  input  logic               i_rst_n,
  input  logic               i_fs_to_ds_valid,
  input  logic [INST_WD-1:0] i_fs_inst,
  input  logic [XLEN-1:0]    i_fs_pc,
  input  logic               i_es_allowin,
  input  logic               i_load_stall,
  input  logic               i_br_taken,
  output logic               o_ds_allowin,
  output logic               o_ds_to_es_valid,
  output logic [INST_WD-1:0] o_ds_inst,
  output logic [XLEN-1:0]    o_ds_pc
);

  logic ds_valid;
  logic ds_ready_go;
  logic load_en;

  assign ds_ready_go      = !i_load_stall;
  assign o_ds_allowin     = !ds_valid || (ds_ready_go && i_es_allowin);
  assign o_ds_to_es_valid = ds_valid && ds_ready_go;
  assign load_en          = i_fs_to_ds_valid && o_ds_allowin;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      ds_valid  <= 1'b0;
      o_ds_inst <= NOP_INST;
    end else begin
      if (o_ds_allowin) ds_valid <= i_fs_to_ds_valid;
      if (load_en) o_ds_inst <= i_br_taken ? NOP_INST : i_fs_inst; // wrong-path slot
    end
  end

  always_ff @(posedge i_clk) begin
    if (load_en) o_ds_pc <= i_fs_pc;
  end

endmodule

`default_nettype wire

// ==== src/id_stage.sv ====
// decode stage top, connects the stage register, decoder, register file, bypass and branch unit
`timescale 1ns/1ns
`default_nettype none

module id_stage import id_pkg::*; #(
  parameter int XLEN = id_pkg::XLEN
) (
  input  logic                   i_clk,
  input  logic                   i_rst_n,
  // fetch side
  input  logic                   i_fs_to_ds_valid,
  input  logic [INST_WD-1:0]     i_fs_inst,
  input  logic [XLEN-1:0]        i_fs_pc,
  output logic                   o_ds_allowin,
  output logic                   o_br_taken,
  output logic                   o_br_sel,
  output logic [XLEN-1:0]        o_br_target,
  // execute side
  input  logic                   i_es_allowin,
  output logic                   o_ds_to_es_valid,
  output logic [GPR_ADDR_WD-1:0] o_rd,
  output logic [XLEN-1:0]        o_imm,
  output logic [4:0]             o_alu_op,
  output logic                   o_src1_sel,
  output logic [1:0]             o_src2_sel,
  output logic                   o_gpr_wen,
  output logic                   o_mem_ren,
  output logic                   o_mem_wen,
  output logic [2:0]             o_mem_op,
  output logic                   o_load_sel,
  output logic                   o_invalid,
  output logic [XLEN-1:0]        o_rs1_data,
  output logic [XLEN-1:0]        o_rs2_data,
  output logic [XLEN-1:0]        o_ds_pc,
  // write-back
  input  logic                   i_wb_wen,
  input  logic [GPR_ADDR_WD-1:0] i_wb_addr,
  input  logic [XLEN-1:0]        i_wb_data,
  // forwarding
  input  logic                   i_es_load_sel,
  input  logic [GPR_ADDR_WD-1:0] i_es_fwd_rd,
  input  logic [XLEN-1:0]        i_es_fwd_data,
  input  logic [GPR_ADDR_WD-1:0] i_ms_fwd_rd,
  input  logic [XLEN-1:0]        i_ms_fwd_data,
  input  logic [GPR_ADDR_WD-1:0] i_ws_fwd_rd,
  input  logic [XLEN-1:0]        i_ws_fwd_data
);

  logic [INST_WD-1:0] ds_inst;
  logic               load_stall;
  logic [XLEN-1:0]    rf_rdata1;
  logic [XLEN-1:0]    rf_rdata2;
  fwd_t               es_fwd;
  fwd_t               ms_fwd;
  fwd_t               ws_fwd;

  decode_if u_dif ();

  assign es_fwd = '{rd: i_es_fwd_rd, data: i_es_fwd_data};
  assign ms_fwd = '{rd: i_ms_fwd_rd, data: i_ms_fwd_data};
  assign ws_fwd = '{rd: i_ws_fwd_rd, data: i_ws_fwd_data};

  id_pipe_reg u_pipe_reg (
    .i_clk            (i_clk),
    .i_rst_n          (i_rst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_load_stall     (load_stall),
    .i_br_taken       (o_br_taken),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_ds_inst        (ds_inst),
    .o_ds_pc          (o_ds_pc)
  );

  id_decoder u_decoder (
    .i_inst (ds_inst),
    .dif    (u_dif.decoder)
  );

  id_gpr_file #(.XLEN(XLEN)) u_gpr_file (
    .i_clk    (i_clk),
    .i_rst_n  (i_rst_n),
    .i_raddr1 (u_dif.rs1),
    .i_raddr2 (u_dif.rs2),
    .i_wen    (i_wb_wen),
    .i_waddr  (i_wb_addr),
    .i_wdata  (i_wb_data),
    .o_rdata1 (rf_rdata1),
    .o_rdata2 (rf_rdata2)
  );

  id_operand_bypass u_bypass (
    .op            (u_dif.operand),
    .i_rf_rdata1   (rf_rdata1),
    .i_rf_rdata2   (rf_rdata2),
    .i_es_fwd      (es_fwd),
    .i_ms_fwd      (ms_fwd),
    .i_ws_fwd      (ws_fwd),
    .i_es_load_sel (i_es_load_sel),
    .o_rs1_data    (o_rs1_data),
    .o_rs2_data    (o_rs2_data),
    .o_load_stall  (load_stall)
  );

  id_branch_unit u_branch (
    .br          (u_dif.branch),
    .i_issue     (o_ds_to_es_valid), // no redirect while stalled
    .i_rs1_data  (o_rs1_data),
    .i_rs2_data  (o_rs2_data),
    .i_ds_pc     (o_ds_pc),
    .i_fs_pc     (i_fs_pc),
    .o_br_sel    (o_br_sel),
    .o_br_taken  (o_br_taken),
    .o_br_target (o_br_target)
  );

  assign o_rd       = u_dif.rd;
  assign o_imm      = u_dif.imm;
  assign o_alu_op   = u_dif.alu_op;
  assign o_src1_sel = u_dif.src1_sel;
  assign o_src2_sel = u_dif.src2_sel;
  assign o_gpr_wen  = u_dif.gpr_wen;
  assign o_mem_ren  = u_dif.mem_ren;
  assign o_mem_wen  = u_dif.mem_wen;
  assign o_mem_op   = u_dif.mem_op;
  assign o_load_sel = u_dif.load_sel;
  assign o_invalid  = u_dif.invalid;

endmodule

`default_nettype wire

// ==== sim/id_stage_chk.sv ====
// concurrent handshake and branch assertions, bound into every id_stage instance
`timescale 1ns/1ns
`default_nettype none

module id_stage_chk import id_pkg::*; (
  input logic                   i_clk,
  input logic                   i_rst_n,
  input logic                   i_es_allowin,
  input logic                   i_load_stall,
  input logic                   i_ds_allowin,
  input logic                   i_ds_to_es_valid,
  input logic                   i_br_taken,
  input logic                   i_br_sel,
  input logic [GPR_ADDR_WD-1:0] i_rd,
  input logic [4:0]             i_alu_op,
  input logic [XLEN-1:0]        i_imm,
  input logic [XLEN-1:0]        i_ds_pc
);

  logic blocked;
  int   fail_cnt = 0;

  assign blocked = i_ds_to_es_valid && !i_es_allowin; // execute not taking the issue

  a_no_allowin_when_blocked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    blocked |-> !i_ds_allowin)
    else begin
      $error("o_ds_allowin high while the stage is blocked");
      fail_cnt++;
    end

  a_taken_needs_sel: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_br_taken |-> i_br_sel)
    else begin
      $error("o_br_taken without o_br_sel");
      fail_cnt++;
    end

  a_hold_when_blocked: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    blocked |=> ($stable(i_rd) && $stable(i_alu_op) && $stable(i_imm) && $stable(i_ds_pc)))
    else begin
      $error("decoded outputs changed under back-pressure");
      fail_cnt++;
    end

  a_no_issue_on_stall: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_load_stall |-> !i_ds_to_es_valid)
    else begin
      $error("o_ds_to_es_valid high during a load-use stall");
      fail_cnt++;
    end

endmodule

bind id_stage id_stage_chk u_chk (
  .i_clk            (i_clk),
  .i_rst_n          (i_rst_n),
  .i_es_allowin     (i_es_allowin),
  .i_load_stall     (load_stall),
  .i_ds_allowin     (o_ds_allowin),
  .i_ds_to_es_valid (o_ds_to_es_valid),
  .i_br_taken       (o_br_taken),
  .i_br_sel         (o_br_sel),
  .i_rd             (o_rd),
  .i_alu_op         (o_alu_op),
  .i_imm            (o_imm),
  .i_ds_pc          (o_ds_pc)
);

`default_nettype wire

// ==== sim/tb_id_stage.sv ====
// directed testbench of the decode stage, run as top module tb_id_stage with sources.f
`timescale 1ns/1ns
`default_nettype none

module tb_id_stage import id_pkg::*; ();

  localparam int CLK_PERIOD = 8;
  localparam int NUM_STEPS  = 60; // cycles the tests take, roughly

  logic                   i_clk = 1'b0;
  logic                   i_rst_n;
  logic                   i_fs_to_ds_valid;
  logic [INST_WD-1:0]     i_fs_inst;
  logic [XLEN-1:0]        i_fs_pc;
  logic                   o_ds_allowin;
  logic                   o_br_taken;
  logic                   o_br_sel;
  logic [XLEN-1:0]        o_br_target;
  logic                   i_es_allowin;
  logic                   o_ds_to_es_valid;
  logic [GPR_ADDR_WD-1:0] o_rd;
  logic [XLEN-1:0]        o_imm;
  logic [4:0]             o_alu_op;
  logic                   o_src1_sel;
  logic [1:0]             o_src2_sel;
  logic                   o_gpr_wen;
  logic                   o_mem_ren;
  logic                   o_mem_wen;
  logic [2:0]             o_mem_op;
  logic                   o_load_sel;
  logic                   o_invalid;
  logic [XLEN-1:0]        o_rs1_data;
  logic [XLEN-1:0]        o_rs2_data;
  logic [XLEN-1:0]        o_ds_pc;
  logic                   i_wb_wen;
  logic [GPR_ADDR_WD-1:0] i_wb_addr;
  logic [XLEN-1:0]        i_wb_data;
  logic                   i_es_load_sel;
  logic [GPR_ADDR_WD-1:0] i_es_fwd_rd;
  logic [XLEN-1:0]        i_es_fwd_data;
  logic [GPR_ADDR_WD-1:0] i_ms_fwd_rd;
  logic [XLEN-1:0]        i_ms_fwd_data;
  logic [GPR_ADDR_WD-1:0] i_ws_fwd_rd;
  logic [XLEN-1:0]        i_ws_fwd_data;

  string test_name;

  id_stage #(.XLEN(XLEN)) DUT (.*);

  always #(CLK_PERIOD/2) i_clk = ~i_clk;

  // instruction formats from the ISA manual
  function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3,
                                        input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, 7'b0110011};
  endfunction

  function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                        input logic [2:0] f3, input logic [4:0] rd,
                                        input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                        input logic [4:0] rs1, input logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'b1100011};
  endfunction

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  task automatic check(input string what, input logic [63:0] exp, input logic [63:0] act);
    if (act !== exp) begin
      abort_run($sformatf("CHECK FAILED %s: %s expected %h actual %h",
                          test_name, what, exp, act));
    end
  endtask

  task automatic next_cycle();
    @(posedge i_clk);
    #1;
  endtask

  task automatic wb_write(input logic [4:0] addr, input logic [63:0] data);
    next_cycle();
    i_wb_wen  = 1'b1;
    i_wb_addr = addr;
    i_wb_data = data;
    next_cycle();
    i_wb_wen  = 1'b0;
  endtask

  // hands one instruction to the stage, returns 2 ns after the accepting edge
  task automatic send_inst(input logic [31:0] inst, input logic [63:0] pc);
    int waited;
    waited = 0;
    next_cycle();
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst        = inst;
    i_fs_pc          = pc;
    #1;
    while (!o_ds_allowin) begin
      if (waited == 20) begin
        abort_run($sformatf("stage never accepted an instruction in test %s", test_name));
      end
      @(posedge i_clk);
      #2;
      waited++;
    end
    next_cycle();
    i_fs_to_ds_valid = 1'b0;
    #1;
  endtask

  task automatic test_reset();
    test_name = "reset";
    check("valid", 1'b0, o_ds_to_es_valid);
    check("br_sel", 1'b0, o_br_sel);
    check("br_taken", 1'b0, o_br_taken);
    check("allowin", 1'b1, o_ds_allowin);
  endtask

  task automatic test_decode();
    test_name = "decode";
    wb_write(5'd5, 64'h1234_5678_9abc_def0);
    wb_write(5'd6, 64'h0000_0000_0000_1111);
    send_inst(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7), 64'h100);
    check("valid", 1'b1, o_ds_to_es_valid);
    check("rs1", 64'h1234_5678_9abc_def0, o_rs1_data);
    check("rs2", 64'h0000_0000_0000_1111, o_rs2_data);
    check("rd", 7, o_rd);
    check("alu_op", ALU_ADD, o_alu_op);
    check("src1_sel", SRC1_RS1, o_src1_sel);
    check("src2_sel", SRC2_RS2, o_src2_sel);
    check("gpr_wen", 1'b1, o_gpr_wen);
    send_inst(enc_i(12'hffd, 5'd5, 3'b000, 5'd8, 7'b0010011), 64'h104);
    check("addi rd", 8, o_rd);
    check("addi imm", 64'hffff_ffff_ffff_fffd, o_imm);
    check("addi alu_op", ALU_ADD, o_alu_op);
    check("addi src2_sel", SRC2_IMM, o_src2_sel);
    check("addi rs1", 64'h1234_5678_9abc_def0, o_rs1_data);
    send_inst(32'h0000_03ff, 64'h108); // opcode 7f is not in the subset
    check("invalid", 1'b1, o_invalid);
    check("bad gpr_wen", 1'b0, o_gpr_wen);
    send_inst(enc_i(12'd8, 5'd5, 3'b011, 5'd13, 7'b0000011), 64'h180); // ld x13, 8(x5)
    check("ld mem_ren", 1'b1, o_mem_ren);
    check("ld load_sel", 1'b1, o_load_sel);
    check("ld mem_wen", 1'b0, o_mem_wen);
    check("ld mem_op", MEM_D, o_mem_op);
    check("ld gpr_wen", 1'b1, o_gpr_wen);
    send_inst({7'h00, 5'd6, 5'd5, 3'b010, 5'd4, 7'b0100011}, 64'h184); // sw x6, 4(x5)
    check("sw mem_wen", 1'b1, o_mem_wen);
    check("sw mem_ren", 1'b0, o_mem_ren);
    check("sw mem_op", MEM_W, o_mem_op);
    check("sw imm", 64'd4, o_imm);
    check("sw gpr_wen", 1'b0, o_gpr_wen);
  endtask

  task automatic test_forwarding();
    test_name = "forwarding";
    send_inst(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd9), 64'h10c);
    next_cycle();
    i_es_fwd_rd   = 5'd5;
    i_es_fwd_data = 64'haaaa;
    i_ms_fwd_rd   = 5'd5;
    i_ms_fwd_data = 64'hbbbb;
    i_ws_fwd_rd   = 5'd5;
    i_ws_fwd_data = 64'hcccc;
    #1;
    check("es wins", 64'haaaa, o_rs1_data);
    next_cycle();
    i_es_fwd_rd = 5'd0;
    #1;
    check("ms next", 64'hbbbb, o_rs1_data);
    next_cycle();
    i_ms_fwd_rd = 5'd0;
    #1;
    check("ws next", 64'hcccc, o_rs1_data);
    next_cycle();
    i_ws_fwd_rd = 5'd0;
    #1;
    check("regfile", 64'h1234_5678_9abc_def0, o_rs1_data);
    send_inst(enc_r(7'h00, 5'd6, 5'd0, 3'b000, 5'd9), 64'h110); // rs1 is x0
    check("rd0 ignored", 64'h0, o_rs1_data);
  endtask

  task automatic test_stall();
    test_name = "stall";
    next_cycle();
    i_es_load_sel = 1'b1;
    i_es_fwd_rd   = 5'd6;
    send_inst(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7), 64'h114);
    for (int i = 0; i < 3; i++) begin
      check("stall valid", 1'b0, o_ds_to_es_valid);
      check("stall allowin", 1'b0, o_ds_allowin);
      next_cycle();
    end
    i_es_load_sel = 1'b0;
    i_es_fwd_rd   = 5'd0;
    #1;
    check("resume valid", 1'b1, o_ds_to_es_valid);
    check("resume allowin", 1'b1, o_ds_allowin);
    test_name = "backpressure";
    next_cycle();
    i_es_allowin = 1'b0;
    send_inst(enc_i(12'hffd, 5'd5, 3'b000, 5'd8, 7'b0010011), 64'h200);
    for (int i = 0; i < 3; i++) begin
      next_cycle();
      i_fs_to_ds_valid = 1'b1; // must not get in
      i_fs_inst        = enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd7);
      i_fs_pc          = 64'h204;
      #1;
      check("hold allowin", 1'b0, o_ds_allowin);
      check("hold valid", 1'b1, o_ds_to_es_valid);
      check("hold rd", 8, o_rd);
      check("hold pc", 64'h200, o_ds_pc);
    end
    next_cycle();
    i_es_allowin = 1'b1;
    next_cycle();
    i_fs_to_ds_valid = 1'b0;
    #1;
    check("next rd", 7, o_rd);
    check("next pc", 64'h204, o_ds_pc);
  endtask

  task automatic test_branch();
    test_name = "branch";
    wb_write(5'd10, 64'h40);
    wb_write(5'd11, 64'h40);
    wb_write(5'd12, 64'h3004);
    next_cycle();
    i_es_allowin = 1'b0; // keep the branch issuing
    send_inst(enc_b(13'd16, 5'd11, 5'd10, 3'b000), 64'h1000);
    check("beq sel", 1'b1, o_br_sel);
    check("beq target", 64'h1000 + 64'd16, o_br_target);
    check("beq taken", 1'b1, o_br_taken);
    next_cycle();
    i_fs_pc = 64'h1010;
    #1;
    check("on path taken", 1'b0, o_br_taken);
    check("on path sel", 1'b1, o_br_sel);
    next_cycle();
    i_fs_pc          = 64'h1004;
    i_fs_inst        = enc_i(12'hffd, 5'd5, 3'b000, 5'd8, 7'b0010011);
    i_fs_to_ds_valid = 1'b1;
    i_es_allowin     = 1'b1;
    #1;
    check("flush taken", 1'b1, o_br_taken);
    check("flush allowin", 1'b1, o_ds_allowin);
    next_cycle();
    i_fs_to_ds_valid = 1'b0;
    #1;
    check("nop rd", 0, o_rd);
    check("nop gpr_wen", 1'b0, o_gpr_wen);
    check("nop pc", 64'h1004, o_ds_pc);
    send_inst(enc_b(13'd16, 5'd11, 5'd10, 3'b001), 64'h2000);
    check("bne valid", 1'b1, o_ds_to_es_valid);
    check("bne sel", 1'b0, o_br_sel);
    check("bne taken", 1'b0, o_br_taken);
    send_inst(enc_i(12'd1, 5'd12, 3'b000, 5'd1, 7'b1100111), 64'h2004);
    check("jalr sel", 1'b1, o_br_sel);
    check("jalr src1_sel", SRC1_PC, o_src1_sel);
    check("jalr target", 64'h3004, o_br_target); // 0x3005 with bit 0 cleared
    check("jalr taken", 1'b1, o_br_taken);
  endtask

  initial begin
    #(NUM_STEPS * 20 * CLK_PERIOD);
    abort_run("watchdog expired before the tests finished");
  end

  initial begin
    i_rst_n          = 1'b0;
    i_fs_to_ds_valid = 1'b0;
    i_fs_inst        = NOP_INST;
    i_fs_pc          = '0;
    i_es_allowin     = 1'b1;
    i_wb_wen         = 1'b0;
    i_wb_addr        = '0;
    i_wb_data        = '0;
    i_es_load_sel    = 1'b0;
    i_es_fwd_rd      = '0;
    i_es_fwd_data    = '0;
    i_ms_fwd_rd      = '0;
    i_ms_fwd_data    = '0;
    i_ws_fwd_rd      = '0;
    i_ws_fwd_data    = '0;
    repeat (8) @(posedge i_clk);
    #1;
    i_rst_n = 1'b1;
    #1;
    test_reset();
    test_decode();
    test_forwarding();
    test_stall();
    test_branch();
    if (DUT.u_chk.fail_cnt == 0) begin
      $display("All tests passed");
    end else begin
      $display("Some tests failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== sources.f ====
src/id_pkg.sv
src/decode_if.sv
src/id_decoder.sv
src/id_gpr_file.sv
src/id_operand_bypass.sv
src/id_branch_unit.sv
src/id_pipe_reg.sv
src/id_stage.sv
sim/id_stage_chk.sv
sim/tb_id_stage.sv

// ==== Bender.yml ====
package:
  name: id_stage

sources:
  - src/id_pkg.sv
  - src/decode_if.sv
  - src/id_decoder.sv
  - src/id_gpr_file.sv
  - src/id_operand_bypass.sv
  - src/id_branch_unit.sv
  - src/id_pipe_reg.sv
  - src/id_stage.sv
  - target: simulation
    files:
      - sim/id_stage_chk.sv
      - sim/tb_id_stage.sv
